/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - src/fetch_pkg.sv
  - src/redirect_select.sv
  - src/fetch_request_ctrl.sv
  - src/fetch_inst_buffer.sv
  - src/fetch_top.sv
  - target: simulation
    files:
      - sim/inst_sram_model.sv
      - sim/fetch_props.sv
      - sim/fetch_tb.sv

/* flist.f */
src/fetch_pkg.sv
src/redirect_select.sv
src/fetch_request_ctrl.sv
src/fetch_inst_buffer.sv
src/fetch_top.sv
sim/inst_sram_model.sv
sim/fetch_props.sv
sim/fetch_tb.sv

/* sim/fetch_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_props (
    input wire                        clk,
    input wire                        resetn,
    input wire                        out_valid,
    input wire                        id_allowin,
    input wire fetch_pkg::fetch_out_t out_data,
    input wire                        out_adef
);
    // read by the testbench at the end of the run
    int fail_count = 0;

    // the stage is cleared by each reset edge
    no_valid_in_reset: assert property (
        @(posedge clk) !resetn |=> !out_valid
    ) else begin
        fail_count++;
        $error("out_valid high during reset");
    end

    // a stalled word must not move until decode takes it
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!resetn)
        (out_valid && !id_allowin) |=> (!out_valid || $stable(out_data))
    ) else begin
        fail_count++;
        $error("out_data changed while decode stalled");
    end

    adef_matches_pc: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid |-> (out_adef == (out_data.pc[1:0] != 2'b00))
    ) else begin
        fail_count++;
        $error("out_adef does not match low pc bits");
    end

endmodule

bind fetch_top fetch_props i_fetch_props (
    .clk        (clk),
    .resetn     (resetn),
    .out_valid  (out_valid),
    .id_allowin (id_allowin),
    .out_data   (out_data),
    .out_adef   (out_adef)
);

`default_nettype wire

/* sim/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    localparam int max_cycles = 4000;

    logic clk = 1'b0;
    logic resetn;
    logic id_allowin;
    logic br_taken;
    logic br_stall;
    logic flush;
    logic inst_sram_req;
    logic inst_sram_addr_ok;
    logic inst_sram_data_ok;
    logic out_valid;
    logic out_adef;
    fetch_pkg::addr_t      br_target;
    fetch_pkg::addr_t      inst_sram_addr;
    fetch_pkg::addr_t      exp_pc;
    fetch_pkg::inst_t      inst_sram_rdata;
    fetch_pkg::redirect_t  wb_redirect;
    fetch_pkg::redirect_t  rd;
    fetch_pkg::fetch_out_t out_data;
    int errors = 0;
    int checks = 0;
    int delivered = 0;
    int cycles = 0;
    int tests = 0;

    always #50 clk = ~clk;

    fetch_top i_dut (.*);

    inst_sram_model i_mem (
        .clk (clk), .resetn (resetn), .req (inst_sram_req), .addr (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok), .data_ok (inst_sram_data_ok), .rdata (inst_sram_rdata)
    );

    // expected pc after redirect pulses, by fixed priority
    function automatic fetch_pkg::addr_t pick_target(fetch_pkg::redirect_t r, logic br,
                                                     fetch_pkg::addr_t tgt);
        if (r.ertn_valid) return r.era;
        if (r.ex_valid) return r.ex_entry;
        if (r.refetch_valid) return r.wb_pc + 32'd4;
        if (br) return tgt;
        return exp_pc;
    endfunction

    always @(posedge clk) begin
        if (resetn) begin
            if (flush) assert (!out_valid) else begin
                $display("out_valid high in a flush cycle at %0t", $time);
                errors++;
            end
            if (br_stall) assert (!inst_sram_req) else begin
                $display("request issued while br_stall high at %0t", $time);
                errors++;
            end
            if (out_valid && id_allowin) begin
                checks++;
                assert (out_data.pc == exp_pc) else begin
                    $display("FAIL %0t out_data.pc expected %h got %h", $time, exp_pc,
                             out_data.pc);
                    errors++;
                end
                assert (out_data.inst == (exp_pc ^ 32'ha5a5_a5a5)) else begin
                    $display("FAIL %0t out_data.inst expected %h got %h", $time,
                             exp_pc ^ 32'ha5a5_a5a5, out_data.inst);
                    errors++;
                end
                assert (out_adef == (exp_pc[1:0] != 2'b00)) else begin
                    $display("FAIL %0t out_adef expected %b got %b", $time,
                             exp_pc[1:0] != 2'b00, out_adef);
                    errors++;
                end
                exp_pc = exp_pc + 32'd4;
                delivered++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic wait_deliveries(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(negedge clk);
    endtask

    // decode takes words with random gaps
    task automatic deliver_with_stalls(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            @(negedge clk);
            id_allowin = ($urandom_range(3, 0) != 0);
        end
        @(negedge clk);
        id_allowin = 1'b1;
    endtask

    task automatic pulse_redirect(input fetch_pkg::redirect_t r, input logic br,
                                  input fetch_pkg::addr_t tgt);
        @(negedge clk);
        wb_redirect = r;
        br_taken = br;
        br_target = tgt;
        exp_pc = pick_target(r, br, tgt);
        @(negedge clk);
        wb_redirect = '0;
        br_taken = 1'b0;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int e;
        void'($urandom(32'hf021_223b));
        {resetn, br_taken, br_stall, flush} = '0;
        id_allowin = 1'b1;
        br_target = '0;
        wb_redirect = '0;
        exp_pc = 32'h1c00_0000;
        repeat (10) @(negedge clk);
        resetn = 1'b1;

        e = errors;
        wait_deliveries(20);
        end_test("sequential", e);

        e = errors;
        pulse_redirect('0, 1'b1, 32'h1c00_1000);
        wait_deliveries(5);
        // redirect with a request still in flight
        do @(negedge clk); while (!(inst_sram_req && inst_sram_addr_ok));
        pulse_redirect('0, 1'b1, 32'h1c00_1400);
        wait_deliveries(5);
        end_test("branch", e);

        e = errors;
        rd = '{ertn_valid: 1, ex_valid: 1, refetch_valid: 1, ex_entry: 32'h1c00_8000,
               era: 32'h1c00_4000, wb_pc: 32'h1c00_6000};
        pulse_redirect(rd, 1'b1, 32'h1c00_a000);
        wait_deliveries(3);
        rd.ertn_valid = 1'b0;
        pulse_redirect(rd, 1'b1, 32'h1c00_a000);
        wait_deliveries(3);
        rd.ex_valid = 1'b0;
        pulse_redirect(rd, 1'b1, 32'h1c00_a000);
        wait_deliveries(3);
        pulse_redirect('0, 1'b1, 32'h1c00_a000);
        wait_deliveries(3);
        end_test("priority", e);

        e = errors;
        deliver_with_stalls(30);
        end_test("backpressure", e);

        e = errors;
        pulse_redirect('0, 1'b1, 32'h1c00_2002);
        wait_deliveries(3);
        pulse_redirect('0, 1'b1, 32'h1c00_3000);
        wait_deliveries(2);
        end_test("misaligned", e);

        e = errors;
        do @(negedge clk); while (!out_valid);
        // the flushed word is skipped, fetch resumes after it
        flush = 1'b1;
        exp_pc = exp_pc + 32'd4;
        @(negedge clk);
        flush = 1'b0;
        wait_deliveries(3);
        @(negedge clk);
        br_stall = 1'b1;
        repeat (20) @(negedge clk);
        br_stall = 1'b0;
        wait_deliveries(4);
        end_test("flush_stall", e);

        errors += i_dut.i_fetch_props.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/inst_sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_sram_model (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   req,
    input  wire fetch_pkg::addr_t addr,
    output logic                  addr_ok = 1'b0,
    output logic                  data_ok = 1'b0,
    output fetch_pkg::inst_t      rdata = '0
);
    localparam int max_outstanding = 2;
    localparam logic [31:0] data_key = 32'ha5a5_a5a5;

    fetch_pkg::addr_t pend_addr [$];
    int               pend_wait [$];

    // accepted requests are kept in order, each with its own countdown
    always @(posedge clk) begin
        if (!resetn) begin
            pend_addr.delete();
            pend_wait.delete();
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            rdata   <= '0;
        end else begin
            if (data_ok) begin
                void'(pend_addr.pop_front());
                void'(pend_wait.pop_front());
            end
            foreach (pend_wait[i]) begin
                if (pend_wait[i] > 0) begin
                    pend_wait[i] = pend_wait[i] - 1;
                end
            end
            if (req && addr_ok) begin
                pend_addr.push_back(addr);
                // 0 here means the response shows one cycle later
                pend_wait.push_back($urandom_range(3, 0));
            end
            addr_ok <= (pend_addr.size() < max_outstanding) && ($urandom_range(3, 0) != 0);
            if (pend_addr.size() > 0 && pend_wait[0] == 0) begin
                data_ok <= 1'b1;
                rdata   <= pend_addr[0] ^ data_key;
            end else begin
                data_ok <= 1'b0;
                rdata   <= $urandom;
            end
        end
    end

endmodule

`default_nettype wire

/* src/fetch_inst_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_inst_buffer (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   stage_valid,
    input  wire fetch_pkg::addr_t fetch_pc,
    input  wire                   resp_keep,
    input  wire                   redirect_now,
    input  wire                   flush,
    input  wire                   id_allowin,
    input  wire fetch_pkg::inst_t inst_sram_rdata,
    output logic                  stage_ready_go,
    output logic                  out_valid,
    output fetch_pkg::fetch_out_t out_data,
    output logic                  out_adef
);
    logic             buf_valid;
    fetch_pkg::inst_t buf_inst;
    fetch_pkg::inst_t inst_sel;
    logic             transfer;
    logic             capture;

    assign stage_ready_go = buf_valid | resp_keep;

    // wrong-path word is never shown to decode
    assign out_valid = stage_valid & stage_ready_go & ~redirect_now & ~flush;
    assign transfer  = out_valid & id_allowin;

    // bypass straight from memory when nothing is buffered
    assign inst_sel = buf_valid ? buf_inst : inst_sram_rdata;

    assign out_data.inst = inst_sel;
    assign out_data.pc   = fetch_pc;
    assign out_adef      = |fetch_pc[1:0];

    // decode stalled in the cycle the word came back
    assign capture = stage_valid & resp_keep & ~buf_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (transfer || redirect_now || flush) begin
            buf_valid <= 1'b0;
        end else if (capture) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_inst <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // one instruction address
    typedef logic [31:0] addr_t;

    // one raw instruction word
    typedef logic [31:0] inst_t;

    // redirect requests from write-back, 99 bits
    typedef struct packed {
        // return from exception
        logic  ertn_valid;
        // exception entry
        logic  ex_valid;
        // tlb refetch of the instruction at wb_pc
        logic  refetch_valid;
        addr_t ex_entry;
        // exception return address
        addr_t era;
        addr_t wb_pc;
    } redirect_t;

    // handoff to decode, 64 bits
    typedef struct packed {
        inst_t inst;
        addr_t pc;
    } fetch_out_t;

    // byte distance between sequential instructions
    localparam addr_t inst_step = 32'd4;

endpackage

`default_nettype wire

/* src/fetch_request_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_request_ctrl #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1bff_fffc,
    parameter int               CANCEL_W = 4
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire fetch_pkg::addr_t next_pc,
    input  wire                   redirect_now,
    input  wire                   br_stall,
    input  wire                   flush,
    input  wire                   id_allowin,
    input  wire                   stage_ready_go,
    input  wire                   inst_sram_addr_ok,
    input  wire                   inst_sram_data_ok,
    output logic                  inst_sram_req,
    output fetch_pkg::addr_t      inst_sram_addr,
    output logic                  addr_accept,
    output fetch_pkg::addr_t      fetch_pc,
    output logic                  stage_valid,
    output logic                  resp_keep
);
    logic                fetch_en;
    logic                stage_allowin;
    logic                mem_accept;
    logic                drop_accept;
    logic                pre_cancel;
    logic [CANCEL_W-1:0] cancel_cnt;
    logic                cancel_any;
    logic                cancel_inc;
    logic                cancel_dec;

    // the stage takes a new pc when empty, when its word leaves, or when it is discarded
    assign stage_allowin = ~stage_valid
                         | (stage_ready_go & id_allowin)
                         | redirect_now
                         | flush;

    assign inst_sram_req  = fetch_en & stage_allowin & ~br_stall & ~pre_cancel;
    assign inst_sram_addr = next_pc;

    assign mem_accept = inst_sram_req & inst_sram_addr_ok;
    // a flush with no new target kills the request taken in the same cycle
    assign drop_accept = mem_accept & flush & ~redirect_now;
    assign addr_accept = mem_accept & ~drop_accept;

    assign cancel_any = |cancel_cnt;
    assign cancel_inc = (redirect_now | flush) & stage_valid & ~stage_ready_go;
    assign cancel_dec = inst_sram_data_ok & cancel_any;

    assign resp_keep = inst_sram_data_ok & ~cancel_any & ~pre_cancel;

    // hold req low until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (stage_allowin) begin
            stage_valid <= addr_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_pc <= RESET_PC;
        end else if (addr_accept) begin
            fetch_pc <= next_pc;
        end
    end

    // responses still owed for requests that were redirected away
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else if (cancel_inc && !cancel_dec) begin
            cancel_cnt <= cancel_cnt + 1'b1;
        end else if (cancel_dec && !cancel_inc) begin
            cancel_cnt <= cancel_cnt - 1'b1;
        end
    end

    // older cancelled responses come back first, so the flag waits for the counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_cancel <= 1'b0;
        end else if (drop_accept) begin
            pre_cancel <= 1'b1;
        end else if (inst_sram_data_ok && !cancel_any) begin
            pre_cancel <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1bff_fffc,
    parameter int               CANCEL_W = 4
) (
    input  wire                       clk,
    input  wire                       resetn,
    // instruction sram
    output logic                      inst_sram_req,
    output fetch_pkg::addr_t          inst_sram_addr,
    input  wire                       inst_sram_addr_ok,
    input  wire                       inst_sram_data_ok,
    input  wire fetch_pkg::inst_t     inst_sram_rdata,
    // pipeline control
    input  wire                       id_allowin,
    input  wire                       br_taken,
    input  wire                       br_stall,
    input  wire fetch_pkg::addr_t     br_target,
    input  wire fetch_pkg::redirect_t wb_redirect,
    input  wire                       flush,
    // toward decode
    output logic                      out_valid,
    output fetch_pkg::fetch_out_t     out_data,
    output logic                      out_adef
);
    fetch_pkg::addr_t next_pc;
    fetch_pkg::addr_t fetch_pc;
    logic             redirect_now;
    logic             addr_accept;
    logic             stage_valid;
    logic             stage_ready_go;
    logic             resp_keep;

    redirect_select i_redirect_select (
        .clk          (clk),
        .resetn       (resetn),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .wb_redirect  (wb_redirect),
        .fetch_pc     (fetch_pc),
        .addr_accept  (addr_accept),
        .next_pc      (next_pc),
        .redirect_now (redirect_now)
    );

    fetch_request_ctrl #(
        .RESET_PC (RESET_PC),
        .CANCEL_W (CANCEL_W)
    ) i_fetch_request_ctrl (
        .clk               (clk),
        .resetn            (resetn),
        .next_pc           (next_pc),
        .redirect_now      (redirect_now),
        .br_stall          (br_stall),
        .flush             (flush),
        .id_allowin        (id_allowin),
        .stage_ready_go    (stage_ready_go),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .addr_accept       (addr_accept),
        .fetch_pc          (fetch_pc),
        .stage_valid       (stage_valid),
        .resp_keep         (resp_keep)
    );

    fetch_inst_buffer i_fetch_inst_buffer (
        .clk             (clk),
        .resetn          (resetn),
        .stage_valid     (stage_valid),
        .fetch_pc        (fetch_pc),
        .resp_keep       (resp_keep),
        .redirect_now    (redirect_now),
        .flush           (flush),
        .id_allowin      (id_allowin),
        .inst_sram_rdata (inst_sram_rdata),
        .stage_ready_go  (stage_ready_go),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_adef        (out_adef)
    );

endmodule

`default_nettype wire

/* src/redirect_select.sv */
`timescale 1ns/1ps
`default_nettype none

module redirect_select (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     br_taken,
    input  wire fetch_pkg::addr_t   br_target,
    input  wire fetch_pkg::redirect_t wb_redirect,
    input  wire fetch_pkg::addr_t   fetch_pc,
    input  wire                     addr_accept,
    output fetch_pkg::addr_t        next_pc,
    output logic                    redirect_now
);
    // index 0 is the highest priority
    localparam int n_kinds = 4;

    logic [n_kinds-1:0] pulse;
    logic [n_kinds-1:0] held;
    fetch_pkg::addr_t   target      [n_kinds];
    fetch_pkg::addr_t   held_target [n_kinds];
    fetch_pkg::addr_t   seq_pc;

    // return, exception, refetch, branch
    assign pulse = {
        br_taken,
        wb_redirect.refetch_valid,
        wb_redirect.ex_valid,
        wb_redirect.ertn_valid
    };

    assign target[0] = wb_redirect.era;
    assign target[1] = wb_redirect.ex_entry;
    assign target[2] = wb_redirect.wb_pc + fetch_pkg::inst_step;
    assign target[3] = br_target;

    assign redirect_now = |pulse;
    assign seq_pc       = fetch_pc + fetch_pkg::inst_step;

    // keep a redirect alive until memory takes an address
    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= '0;
        end else if (addr_accept) begin
            held <= '0;
        end else begin
            held <= held | pulse;
        end
    end

    // newest target of each kind
    always_ff @(posedge clk) begin
        for (int i = 0; i < n_kinds; i++) begin
            if (pulse[i]) begin
                held_target[i] <= target[i];
            end
        end
    end

    // walk from lowest priority up so the highest one wins
    always_comb begin
        next_pc = seq_pc;
        for (int i = n_kinds - 1; i >= 0; i--) begin
            if (pulse[i]) begin
                next_pc = target[i];
            end
            if (held[i]) begin
                next_pc = held_target[i];
            end
        end
    end

endmodule

`default_nettype wire
